// ==== hdl/xc_pkg.sv ====
// Shared widths, counts, tag layout and vector types, imported by every correlator block.
`default_nettype none

package xc_pkg;

	// Physical pins and the banks multiplexed over them.
	localparam int NUM_LINES = 2;
	localparam int MUX_LINES = 2;
	// Each bank/line combination is one logical input.
	localparam int NUM_INPUTS = NUM_LINES * MUX_LINES;
	localparam int NUM_PAIRS = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	// A snapshot carries one single count per input, then one count per pair.
	localparam int NUM_WORDS = NUM_INPUTS + NUM_PAIRS;
	localparam int WINDOW_FRAMES = 16;
	localparam int COUNT_W = 4;
	localparam int COUNT_MAX = (1 << COUNT_W) - 1;
	localparam int TAG_W = 4;
	// The FIFO depth doubles as the credit the integrator starts with.
	localparam int EGRESS_DEPTH = 4;
	localparam int CREDIT_W = 3;
	localparam int BANK_W = $clog2(MUX_LINES);
	localparam int FRAME_W = $clog2(WINDOW_FRAMES);
	localparam int PTR_W = $clog2(EGRESS_DEPTH);

	// Pair p correlates inputs PAIR_A[p] and PAIR_B[p], in tag order after the singles.
	localparam int PAIR_A [NUM_PAIRS] = '{0, 0, 0, 1, 1, 2};
	localparam int PAIR_B [NUM_PAIRS] = '{1, 2, 3, 2, 3, 3};

	typedef logic [NUM_LINES-1:0] line_vec_t;
	typedef logic [MUX_LINES-1:0] bank_sel_t;
	typedef logic [BANK_W-1:0] bank_idx_t;
	typedef logic [NUM_INPUTS-1:0] frame_t;
	typedef logic [FRAME_W-1:0] frame_cnt_t;
	typedef logic [COUNT_W-1:0] count_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [CREDIT_W-1:0] credit_t;
	typedef logic [PTR_W-1:0] fifo_ptr_t;
	// The tag sits in the upper half so a consumer can sort words by the top nibble.
	typedef logic [TAG_W+COUNT_W-1:0] result_word_t;

	// The sampler either drives one bank or holds with the sample-and-hold in reset.
	typedef enum logic {
		SCAN_BANK,
		SCAN_HOLD
	} scan_state_t;

endpackage

`default_nettype wire

// ==== hdl/line_scan_sampler.sv ====
// Stage 1: scans the multiplexed line banks and emits one complete pulse frame per scan.
`timescale 1ns/1ps
`default_nettype none

module line_scan_sampler (
	input  wire               pll_clk,
	input  wire               rst_n,
	input  wire               enable,
	input  xc_pkg::line_vec_t line_in,
	output xc_pkg::bank_sel_t bank_sel,
	output logic              sh_reset,
	output logic              frame_valid,
	output xc_pkg::frame_t    frame_bits
);
	import xc_pkg::*;

	scan_state_t state;
	bank_idx_t   bank_idx;
	logic        last_bank;

	assign last_bank = (bank_idx == bank_idx_t'(MUX_LINES - 1));

	// The mux select follows the bank index only while a bank is being sampled.
	always_comb begin
		bank_sel = '0;
		if (state == SCAN_BANK) begin
			bank_sel = bank_sel_t'(1) << bank_idx;
		end
	end

	// The sample-and-hold is reset for the whole hold phase, idle included.
	assign sh_reset = (state == SCAN_HOLD);

	// Walk the banks, then spend one cycle in hold before the next scan.
	// Dropping enable mid-scan abandons the frame.
	always_ff @(posedge pll_clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= SCAN_HOLD;
			bank_idx    <= '0;
			frame_valid <= 1'b0;
		end else begin
			frame_valid <= 1'b0;
			if (state == SCAN_HOLD) begin
				bank_idx <= '0;
				if (enable) begin
					state <= SCAN_BANK;
				end
			end else if (!enable) begin
				state <= SCAN_HOLD;
			end else if (last_bank) begin
				// The frame is complete on this edge and is flagged during hold.
				state       <= SCAN_HOLD;
				frame_valid <= 1'b1;
			end else begin
				bank_idx <= bank_idx + bank_idx_t'(1);
			end
		end
	end

	// Each bank's pins land in their own slice, indexed bank times NUM_LINES plus line.
	always_ff @(posedge pll_clk) begin
		if (state == SCAN_BANK) begin
			frame_bits[bank_idx*NUM_LINES +: NUM_LINES] <= line_in;
		end
	end

	// Only one bank may be routed at a time, and never while the hold is in reset.
	a_bank_sel_legal: assert property (@(posedge pll_clk) disable iff (!rst_n)
		$onehot0(bank_sel) && !(sh_reset && (bank_sel != '0)));

endmodule

`default_nettype wire

// ==== hdl/coincidence_integrator.sv ====
// Stage 2: integrates single and pair pulse counts per window and streams tagged snapshots.
`timescale 1ns/1ps
`default_nettype none

module coincidence_integrator (
	input  wire                  pll_clk,
	input  wire                  rst_n,
	input  wire                  frame_valid,
	input  xc_pkg::frame_t       frame_bits,
	output logic                 word_valid,
	output xc_pkg::result_word_t word_data,
	input  wire                  word_credit,
	output logic                 window_overrun
);
	import xc_pkg::*;

	count_t     single_cnt [NUM_INPUTS];
	count_t     pair_cnt [NUM_PAIRS];
	count_t     single_next [NUM_INPUTS];
	count_t     pair_next [NUM_PAIRS];
	count_t     snap [NUM_WORDS];
	frame_cnt_t frame_cnt;
	credit_t    credit;
	tag_t       send_tag;
	logic       busy;
	logic       window_close;
	logic       word_send;

	// Counts stick at the maximum instead of wrapping.
	function automatic count_t sat_inc(count_t c, logic hit);
		count_t r;
		r = c;
		if (hit && (c != count_t'(COUNT_MAX))) begin
			r = c + count_t'(1);
		end
		return r;
	endfunction

	// Next counts include the current frame, so the closing frame reaches the snapshot.
	always_comb begin
		for (int i = 0; i < NUM_INPUTS; i++) begin
			single_next[i] = sat_inc(single_cnt[i], frame_bits[i]);
		end
		// A coincidence is both inputs of the pair pulsing in the same frame.
		for (int p = 0; p < NUM_PAIRS; p++) begin
			pair_next[p] = sat_inc(pair_cnt[p], frame_bits[PAIR_A[p]] & frame_bits[PAIR_B[p]]);
		end
	end

	assign window_close = frame_valid && (frame_cnt == frame_cnt_t'(WINDOW_FRAMES - 1));

	// A word goes out only when the egress FIFO has promised room for it.
	assign word_valid = busy && (credit != '0);
	assign word_send = word_valid;
	assign word_data = {send_tag, snap[send_tag]};

	// Counters clear at window close so the next frame starts a fresh window.
	always_ff @(posedge pll_clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_cnt <= '0;
			for (int i = 0; i < NUM_INPUTS; i++) begin
				single_cnt[i] <= '0;
			end
			for (int p = 0; p < NUM_PAIRS; p++) begin
				pair_cnt[p] <= '0;
			end
		end else if (frame_valid) begin
			frame_cnt <= window_close ? '0 : frame_cnt + frame_cnt_t'(1);
			for (int i = 0; i < NUM_INPUTS; i++) begin
				single_cnt[i] <= window_close ? '0 : single_next[i];
			end
			for (int p = 0; p < NUM_PAIRS; p++) begin
				pair_cnt[p] <= window_close ? '0 : pair_next[p];
			end
		end
	end

	// The snapshot is only taken when the previous one has fully drained.
	always_ff @(posedge pll_clk) begin
		if (window_close && !busy) begin
			for (int i = 0; i < NUM_INPUTS; i++) begin
				snap[i] <= single_next[i];
			end
			for (int p = 0; p < NUM_PAIRS; p++) begin
				snap[NUM_INPUTS+p] <= pair_next[p];
			end
		end
	end

	// Streaming walks the tags in order; a close during streaming is an overrun.
	always_ff @(posedge pll_clk or negedge rst_n) begin
		if (!rst_n) begin
			busy           <= 1'b0;
			send_tag       <= '0;
			window_overrun <= 1'b0;
		end else begin
			if (window_close && busy) begin
				window_overrun <= 1'b1;
			end
			if (window_close && !busy) begin
				busy     <= 1'b1;
				send_tag <= '0;
			end else if (word_send) begin
				send_tag <= send_tag + tag_t'(1);
				if (send_tag == tag_t'(NUM_WORDS - 1)) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// One credit is spent per word and one comes back per FIFO pop.
	always_ff @(posedge pll_clk or negedge rst_n) begin
		if (!rst_n) begin
			credit <= credit_t'(EGRESS_DEPTH);
		end else begin
			case ({word_credit, word_send})
				2'b10:   credit <= credit + credit_t'(1);
				2'b01:   credit <= credit - credit_t'(1);
				default: credit <= credit;
			endcase
		end
	end

	// The FIFO never returns more credit than it was given.
	a_credit_bound: assert property (@(posedge pll_clk) disable iff (!rst_n)
		credit <= credit_t'(EGRESS_DEPTH));
	// A word is never offered without credit, even one cycle after the last was spent.
	a_send_credited: assert property (@(posedge pll_clk) disable iff (!rst_n)
		(word_send && !word_credit && (credit == credit_t'(1))) |=> !word_valid);

endmodule

`default_nettype wire

// ==== hdl/credit_egress_fifo.sv ====
// Stage 3: buffers snapshot words and releases them to the consumer against its credits.
`timescale 1ns/1ps
`default_nettype none

module credit_egress_fifo (
	input  wire                  pll_clk,
	input  wire                  rst_n,
	input  wire                  word_valid,
	input  xc_pkg::result_word_t word_data,
	output logic                 word_credit,
	input  wire                  out_credit,
	output logic                 out_valid,
	output xc_pkg::result_word_t out_word
);
	import xc_pkg::*;

	result_word_t mem [EGRESS_DEPTH];
	fifo_ptr_t    wr_ptr;
	fifo_ptr_t    rd_ptr;
	credit_t      fill;
	credit_t      ext_credit;
	logic         pop;

	// Occupancy and credit are registered, so a word written this cycle waits one cycle.
	assign pop = (fill != '0) && (ext_credit != '0);
	assign out_valid = pop;
	assign out_word = mem[rd_ptr];

	// Storage carries payload only.
	always_ff @(posedge pll_clk) begin
		if (word_valid) begin
			mem[wr_ptr] <= word_data;
		end
	end

	always_ff @(posedge pll_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			fill        <= '0;
			ext_credit  <= '0;
			word_credit <= 1'b0;
		end else begin
			if (word_valid) begin
				wr_ptr <= wr_ptr + fifo_ptr_t'(1);
			end
			if (pop) begin
				rd_ptr <= rd_ptr + fifo_ptr_t'(1);
			end
			case ({word_valid, pop})
				2'b10:   fill <= fill + credit_t'(1);
				2'b01:   fill <= fill - credit_t'(1);
				default: fill <= fill;
			endcase
			// Outside credit saturates; a consumer flooding credits loses nothing it paid for.
			case ({out_credit, pop})
				2'b10: begin
					if (ext_credit != '1) begin
						ext_credit <= ext_credit + credit_t'(1);
					end
				end
				2'b01:   ext_credit <= ext_credit - credit_t'(1);
				default: ext_credit <= ext_credit;
			endcase
			// The freed slot is handed back to the integrator a cycle after the pop.
			word_credit <= pop;
		end
	end

	// A write into a full FIFO means the integrator sent without credit.
	a_no_overflow: assert property (@(posedge pll_clk) disable iff (!rst_n)
		word_valid |-> (fill != credit_t'(EGRESS_DEPTH)));

endmodule

`default_nettype wire

// ==== hdl/xc_correlator_top.sv ====
// Top level of the correlator front end; joins sampler, integrator and egress FIFO in a pipeline.
`timescale 1ns/1ps
`default_nettype none

module xc_correlator_top (
	input  wire                  pll_clk,
	input  wire                  rst_n,
	input  wire                  enable,
	input  xc_pkg::line_vec_t    line_in,
	input  wire                  out_credit,
	output xc_pkg::bank_sel_t    bank_sel,
	output logic                 sh_reset,
	output logic                 out_valid,
	output xc_pkg::result_word_t out_word,
	output logic                 window_overrun
);
	import xc_pkg::*;

	// Frame link, never stalled.
	logic         frame_valid;
	frame_t       frame_bits;
	// Word link, paced by credits returned from the FIFO.
	logic         word_valid;
	result_word_t word_data;
	logic         word_credit;

	line_scan_sampler u_sampler (
		.pll_clk     (pll_clk),
		.rst_n       (rst_n),
		.enable      (enable),
		.line_in     (line_in),
		.bank_sel    (bank_sel),
		.sh_reset    (sh_reset),
		.frame_valid (frame_valid),
		.frame_bits  (frame_bits)
	);

	coincidence_integrator u_integrator (
		.pll_clk        (pll_clk),
		.rst_n          (rst_n),
		.frame_valid    (frame_valid),
		.frame_bits     (frame_bits),
		.word_valid     (word_valid),
		.word_data      (word_data),
		.word_credit    (word_credit),
		.window_overrun (window_overrun)
	);

	credit_egress_fifo u_egress (
		.pll_clk     (pll_clk),
		.rst_n       (rst_n),
		.word_valid  (word_valid),
		.word_data   (word_data),
		.word_credit (word_credit),
		.out_credit  (out_credit),
		.out_valid   (out_valid),
		.out_word    (out_word)
	);

endmodule

`default_nettype wire

// ==== testbench/xc_correlator_tb.sv ====
// Self-checking testbench for the correlator top level; runs every test line of the pattern file.
`timescale 1ns/1ps
`default_nettype none

module xc_correlator_tb;
	import xc_pkg::*;

	logic         pll_clk = 1'b0;
	logic         rst_n;
	logic         enable;
	line_vec_t    line_in;
	logic         out_credit;
	bank_sel_t    bank_sel;
	logic         sh_reset;
	logic         out_valid;
	result_word_t out_word;
	logic         window_overrun;

	// Each test entry is pattern A, pattern B, n, credit mode, then the ten expected words.
	// The memory has room for sixteen entries.
	logic [7:0]  pat_mem [0:16*(4+NUM_WORDS)-1];
	logic [31:0] lcg_state = 32'd84209;
	int          num_tests;
	int          test_errors;
	int          total_errors;
	int          failed_tests;
	int          credits_given;
	int          words_seen;
	int          cycle_count = 0;
	int          cycle_limit = 1000000;

	xc_correlator_top uut (
		.pll_clk        (pll_clk),
		.rst_n          (rst_n),
		.enable         (enable),
		.line_in        (line_in),
		.out_credit     (out_credit),
		.bank_sel       (bank_sel),
		.sh_reset       (sh_reset),
		.out_valid      (out_valid),
		.out_word       (out_word),
		.window_overrun (window_overrun)
	);

	always #2 pll_clk = ~pll_clk;

	// The run is bounded by a cycle budget sized from the number of tests read.
	always @(posedge pll_clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("Testbench failed");
			$finish;
		end
	end

	// A linear congruential step; bit 16 decides whether a credit is given.
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Holds reset for three cycles with all inputs idle, then checks the reset state.
	task automatic reset_dut();
		test_errors = 0;
		credits_given = 0;
		words_seen = 0;
		@(negedge pll_clk);
		rst_n = 1'b0;
		enable = 1'b0;
		line_in = '0;
		out_credit = 1'b0;
		repeat (3) @(negedge pll_clk);
		assert (bank_sel == '0 && sh_reset && !out_valid && !window_overrun) else begin
			$display("Error: outputs are not at their reset values during reset");
			test_errors++;
		end
		rst_n = 1'b1;
	endtask

	// Runs one window of scans and checks the select sequence bank 0, bank 1, hold.
	// The first n frames carry pattern a, the rest pattern b.
	task automatic drive_window(input frame_t pat_a, input frame_t pat_b, input int n);
		int        f;
		int        phase;
		frame_t    cur;
		bank_sel_t exp_sel;
		enable = 1'b1;
		f = 0;
		phase = 0;
		while (f < WINDOW_FRAMES) begin
			@(negedge pll_clk);
			cur = (f < n) ? pat_a : pat_b;
			exp_sel = (phase == MUX_LINES) ? '0 : (bank_sel_t'(1) << phase);
			assert (bank_sel == exp_sel) else begin
				$display("Mismatch: bank_sel expected %0h got %0h", exp_sel, bank_sel);
				test_errors++;
			end
			assert (sh_reset == (phase == MUX_LINES)) else begin
				$display("Mismatch: sh_reset expected %0h got %0h", phase == MUX_LINES, sh_reset);
				test_errors++;
			end
			// The pins carry the slice of the frame that belongs to the selected bank.
			for (int k = 0; k < MUX_LINES; k++) begin
				if (bank_sel == (bank_sel_t'(1) << k)) begin
					line_in = line_vec_t'(cur >> (k * NUM_LINES));
				end
			end
			if (phase == MUX_LINES - 1) begin
				f++;
			end
			phase = (phase == MUX_LINES) ? 0 : phase + 1;
		end
		// Enable drops in the hold cycle, so the last frame is not abandoned.
		@(negedge pll_clk);
		assert (bank_sel == '0 && sh_reset) else begin
			$display("Error: the scan did not enter hold after the last bank");
			test_errors++;
		end
		enable = 1'b0;
	endtask

	// Collects the ten words of one snapshot, pays credit by mode and checks the pacing.
	task automatic collect_words(input int b, input int mode);
		int           k;
		result_word_t exp_word;
		k = 0;
		while (k < NUM_WORDS) begin
			@(negedge pll_clk);
			if (out_valid) begin
				words_seen++;
				exp_word = pat_mem[b+4+k];
				assert (out_word == exp_word) else begin
					$display("Mismatch: out_word %0d expected %02h got %02h", k, exp_word, out_word);
					test_errors++;
				end
				k++;
			end
			assert (words_seen <= credits_given) else begin
				$display("Error: %0d words released for %0d credits", words_seen, credits_given);
				test_errors++;
			end
			if (mode == 2) begin
				assert (window_overrun) else begin
					$display("Error: window_overrun fell while the snapshot drained");
					test_errors++;
				end
			end else begin
				assert (!window_overrun) else begin
					$display("Error: window_overrun set although no window was discarded");
					test_errors++;
				end
			end
			if (mode == 1) begin
				lcg_state = lcg_next(lcg_state);
				out_credit = lcg_state[16];
			end else begin
				out_credit = 1'b1;
			end
			if (out_credit) begin
				credits_given++;
			end
		end
		// No snapshot may follow, so the output stays quiet even with credit on hand.
		repeat (12) begin
			@(negedge pll_clk);
			assert (!out_valid) else begin
				$display("Error: a word arrived after the snapshot was complete");
				test_errors++;
			end
		end
		out_credit = 1'b0;
	endtask

	task automatic report_test(input string label);
		$display("%s: %s", label, (test_errors == 0) ? "ok" : "FAILED");
		total_errors += test_errors;
		if (test_errors != 0) begin
			failed_tests++;
		end
	endtask

	initial begin
		int     b;
		int     n;
		int     mode;
		frame_t pat_a;
		frame_t pat_b;
		rst_n = 1'b0;
		enable = 1'b0;
		line_in = '0;
		out_credit = 1'b0;
		total_errors = 0;
		failed_tests = 0;
		$readmemh("testbench/xc_patterns.txt", pat_mem);
		// A filled entry ends with the word of tag 9.
		num_tests = 0;
		while (num_tests < 16 && pat_mem[num_tests*(4+NUM_WORDS)+13][7:4] == 4'h9) begin
			num_tests++;
		end
		cycle_limit = num_tests * 4 * WINDOW_FRAMES * (MUX_LINES + 1) + 200;

		// With enable low the sampler stays in hold and nothing reaches the output.
		// The idle span is longer than a full window of scans.
		reset_dut();
		repeat (WINDOW_FRAMES * (MUX_LINES + 1) + 20) begin
			@(negedge pll_clk);
			assert (!out_valid && bank_sel == '0 && sh_reset) else begin
				$display("Error: activity seen while enable is low");
				test_errors++;
			end
			out_credit = 1'b1;
		end
		out_credit = 1'b0;
		if (num_tests == 0) begin
			$display("Error: no tests were read from the pattern file");
			test_errors++;
		end
		report_test("idle with enable low");

		for (int t = 0; t < num_tests; t++) begin
			b = t * (4 + NUM_WORDS);
			pat_a = pat_mem[b][3:0];
			pat_b = pat_mem[b+1][3:0];
			n = int'(pat_mem[b+2]);
			mode = int'(pat_mem[b+3]);
			reset_dut();
			drive_window(pat_a, pat_b, n);
			if (mode == 2) begin
				// Two more windows close while the first snapshot waits for credit.
				// They use swapped patterns, so their counts differ from the first.
				drive_window(pat_b, pat_a, n);
				drive_window(pat_b, pat_a, n);
				@(negedge pll_clk);
				assert (window_overrun) else begin
					$display("Error: window_overrun did not set after the discarded windows");
					test_errors++;
				end
			end
			// Credit is only paid once the window is complete.
			collect_words(b, mode);
			report_test($sformatf("test %0d mode %0d n %0d", t, mode, n));
		end

		$display("%0d tests, %0d failed, %0d errors", num_tests + 1, failed_tests, total_errors);
		if (total_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/xc_patterns.txt ====
// Columns: pattern A, pattern B, frames of A (n), credit mode, words for tags 0 to 9.
// Words hold the tag in the upper nibble and the saturated count in the lower nibble.
03 0C 05 00 05 15 2B 3B 45 50 60 70 80 9B
0F 0F 08 00 0F 1F 2F 3F 4F 5F 6F 7F 8F 9F
02 08 00 00 00 10 20 3F 40 50 60 70 80 90
01 00 10 00 0F 10 20 30 40 50 60 70 80 90
09 06 07 01 07 19 29 37 40 50 67 79 80 90
07 0E 03 01 03 1F 2F 3D 43 53 60 7F 8D 9D
0F 03 02 01 0F 1F 22 32 4F 52 62 72 82 92
05 0A 0C 02 0C 14 2C 34 40 5C 60 70 84 90

// ==== compile.f ====
hdl/xc_pkg.sv
hdl/line_scan_sampler.sv
hdl/coincidence_integrator.sv
hdl/credit_egress_fifo.sv
hdl/xc_correlator_top.sv
testbench/xc_correlator_tb.sv

// ==== Makefile ====
# Verilator build and run of the correlator testbench.

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module xc_correlator_tb -f compile.f -Mdir obj_dir
	./obj_dir/Vxc_correlator_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Testbench failed" sim.log || ! grep -q "Testbench passed" sim.log; then \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
